// File: i_cache.f
src/icache_pkg.sv
src/icache_array_if.sv
src/cache_way_if.sv
src/cache_way.sv
src/cache_sram_2way.sv
src/icache_ctrl.sv
src/i_cache.sv
verification/i_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the i_cache testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module i_cache_tb -f i_cache.f &&
./obj_dir/Vi_cache_tb | tee /dev/stderr | grep -x "Verification passed" > /dev/null &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }

// File: src/cache_sram_2way.sv
module cache_sram_2way (
    input logic           clk,
    input logic           proc_reset_i,
    icache_array_if.array arr
);

    cache_way_if way0_bus ();
    cache_way_if way1_bus ();

    logic [icache_pkg::INDEX_W-1:0] set;
    logic [icache_pkg::TAG_W-1:0]   tag;
    // least recently used way of each set
    logic [icache_pkg::SETS-1:0]    lru_q;
    logic                           victim;

    assign set = arr.line_addr[icache_pkg::INDEX_W-1:0];
    assign tag = arr.line_addr[icache_pkg::LINE_ADDR_W-1:icache_pkg::INDEX_W];

    // both ways see the same lookup
    assign way0_bus.set       = set;
    assign way0_bus.tag       = tag;
    assign way0_bus.fill_data = arr.fill_data;
    assign way1_bus.set       = set;
    assign way1_bus.tag       = tag;
    assign way1_bus.fill_data = arr.fill_data;

    // empty way first, way 0 before way 1, then lru
    always_comb begin
        if (!way0_bus.valid) begin
            victim = 1'b0;
        end else if (!way1_bus.valid) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[set];
        end
    end

    assign way0_bus.write = arr.fill && !victim;
    assign way1_bus.write = arr.fill && victim;

    assign arr.hit   = way0_bus.hit || way1_bus.hit;
    assign arr.rdata = way1_bus.hit ? way1_bus.rdata : way0_bus.rdata;

    always_ff @(posedge clk) begin
        if (proc_reset_i) begin
            lru_q <= '0;
        end else if (arr.fill) begin
            // the freshly filled way becomes most recent
            lru_q[set] <= !victim;
        end else if (arr.hit) begin
            lru_q[set] <= way0_bus.hit;
        end
    end

    cache_way u_way0 (
        .clk          (clk),
        .proc_reset_i (proc_reset_i),
        .bus          (way0_bus.way)
    );

    cache_way u_way1 (
        .clk          (clk),
        .proc_reset_i (proc_reset_i),
        .bus          (way1_bus.way)
    );

    // a line is only ever placed in one way
    a_single_way_hit : assert property (
        @(posedge clk) disable iff (proc_reset_i) !(way0_bus.hit && way1_bus.hit)
    );

endmodule

// File: src/cache_way.sv
module cache_way (
    input logic       clk,
    input logic       proc_reset_i,
    cache_way_if.way  bus
);

    logic [icache_pkg::SETS-1:0]   valid_q;
    logic [icache_pkg::TAG_W-1:0]  tag_q  [icache_pkg::SETS];
    logic [icache_pkg::LINE_W-1:0] data_q [icache_pkg::SETS];

    // per-set valid bits
    always_ff @(posedge clk) begin
        if (proc_reset_i) begin
            valid_q <= '0;
        end else if (bus.write) begin
            valid_q[bus.set] <= 1'b1;
        end
    end

    // tag and line storage
    always_ff @(posedge clk) begin
        if (bus.write) begin
            tag_q[bus.set]  <= bus.tag;
            data_q[bus.set] <= bus.fill_data;
        end
    end

    // lookup of the addressed set
    assign bus.valid = valid_q[bus.set];
    assign bus.rdata = data_q[bus.set];
    assign bus.hit   = valid_q[bus.set] && (tag_q[bus.set] == bus.tag);

endmodule

// File: src/cache_way_if.sv
interface cache_way_if;

    // set and tag from the store
    logic [icache_pkg::INDEX_W-1:0] set;
    logic [icache_pkg::TAG_W-1:0]   tag;
    logic [icache_pkg::LINE_W-1:0]  fill_data;
    logic                           write;

    // per-way lookup result
    logic                          hit;
    logic                          valid;
    logic [icache_pkg::LINE_W-1:0] rdata;

    modport store (
        output set, tag, fill_data, write,
        input  hit, valid, rdata
    );

    modport way (
        input  set, tag, fill_data, write,
        output hit, valid, rdata
    );

endinterface

// File: src/i_cache.sv
module i_cache (
    input  logic                               clk,
    input  logic                               proc_reset_i,
    input  logic                               proc_read_i,
    input  logic [icache_pkg::ADDR_W-1:0]      proc_addr_i,
    output logic [31:0]                        proc_rdata_o,
    output logic                               proc_stall_o,
    output logic                               mem_read_o,
    output logic [icache_pkg::LINE_ADDR_W-1:0] mem_addr_o,
    input  logic [icache_pkg::LINE_W-1:0]      mem_rdata_i,
    input  logic                               mem_ready_i
);

    // controller to two-way store
    icache_array_if arr_bus ();

    icache_ctrl u_ctrl (
        .clk          (clk),
        .proc_reset_i (proc_reset_i),
        .proc_read_i  (proc_read_i),
        .proc_addr_i  (proc_addr_i),
        .proc_rdata_o (proc_rdata_o),
        .proc_stall_o (proc_stall_o),
        .mem_read_o   (mem_read_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_ready_i  (mem_ready_i),
        .arr          (arr_bus.ctrl)
    );

    cache_sram_2way u_sram (
        .clk          (clk),
        .proc_reset_i (proc_reset_i),
        .arr          (arr_bus.array)
    );

endmodule

// File: src/icache_array_if.sv
interface icache_array_if;

    // lookup and fill address
    logic [icache_pkg::LINE_ADDR_W-1:0] line_addr;

    // refill path
    logic [icache_pkg::LINE_W-1:0] fill_data;
    logic                          fill;

    // lookup result is combinational on line_addr
    logic [icache_pkg::LINE_W-1:0] rdata;
    logic                          hit;

    modport ctrl (
        output line_addr, fill_data, fill,
        input  rdata, hit
    );

    modport array (
        input  line_addr, fill_data, fill,
        output rdata, hit
    );

endinterface

// File: src/icache_ctrl.sv
module icache_ctrl (
    input  logic                               clk,
    input  logic                               proc_reset_i,
    input  logic                               proc_read_i,
    input  logic [icache_pkg::ADDR_W-1:0]      proc_addr_i,
    output logic [31:0]                        proc_rdata_o,
    output logic                               proc_stall_o,
    output logic                               mem_read_o,
    output logic [icache_pkg::LINE_ADDR_W-1:0] mem_addr_o,
    input  logic [icache_pkg::LINE_W-1:0]      mem_rdata_i,
    input  logic                               mem_ready_i,
    icache_array_if.ctrl                       arr
);

    icache_pkg::ctrl_state_e state_q;
    icache_pkg::ctrl_state_e state_d;

    logic [icache_pkg::OFFSET_W-1:0]    offset;
    logic [icache_pkg::LINE_ADDR_W-1:0] req_line;
    logic [icache_pkg::LINE_ADDR_W-1:0] next_line;
    logic [icache_pkg::LINE_W-1:0]      line_shift;
    logic                               span_need;
    logic                               enter_span;
    logic                               span_done;

    // span_q is set while working on the second line
    // done_q marks a ready spanning word
    logic                          span_q;
    logic                          done_q;
    logic [15:0]                   last_half_q;
    logic [15:0]                   next_half_q;
    logic [icache_pkg::LINE_W-1:0] fill_q;

    assign offset    = proc_addr_i[icache_pkg::OFFSET_W-1:0];
    assign req_line  = proc_addr_i[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W];
    assign next_line = req_line + 1'b1;

    assign arr.line_addr = span_q ? next_line : req_line;
    assign arr.fill_data = fill_q;
    assign arr.fill      = (state_q == icache_pkg::ST_FILL);

    // window starts at the requested halfword
    // at the last offset the upper half shifts in as zero
    assign line_shift = arr.rdata >> {offset, 4'b0000};

    // 32-bit instruction sitting in the last halfword
    assign span_need = (offset == icache_pkg::OFFSET_W'(icache_pkg::LAST_OFFSET))
                    && (line_shift[1:0] == 2'b11);

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::ST_IDLE: begin
                if (proc_read_i && !done_q) begin
                    if (!arr.hit) begin
                        state_d = icache_pkg::ST_REFILL;
                    end else if (span_need) begin
                        state_d = icache_pkg::ST_SPAN;
                    end
                end
            end
            icache_pkg::ST_SPAN: begin
                state_d = arr.hit ? icache_pkg::ST_IDLE : icache_pkg::ST_REFILL;
            end
            icache_pkg::ST_REFILL: begin
                if (mem_ready_i) begin
                    state_d = icache_pkg::ST_FILL;
                end
            end
            icache_pkg::ST_FILL: begin
                // a refill of the next line goes back for its lookup
                state_d = span_q ? icache_pkg::ST_SPAN : icache_pkg::ST_IDLE;
            end
            default: begin
                state_d = icache_pkg::ST_IDLE;
            end
        endcase
    end

    assign enter_span = (state_q == icache_pkg::ST_IDLE) && (state_d == icache_pkg::ST_SPAN);
    assign span_done  = (state_q == icache_pkg::ST_SPAN) && arr.hit;

    always_ff @(posedge clk) begin
        if (proc_reset_i) begin
            state_q <= icache_pkg::ST_IDLE;
            span_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= span_done;
            if (enter_span) begin
                span_q <= 1'b1;
            end else if (span_done) begin
                span_q <= 1'b0;
            end
        end
    end

    // halves of a spanning word and the returned line
    always_ff @(posedge clk) begin
        if (enter_span) begin
            last_half_q <= line_shift[15:0];
        end
        if (span_done) begin
            next_half_q <= arr.rdata[15:0];
        end
        if ((state_q == icache_pkg::ST_REFILL) && mem_ready_i) begin
            fill_q <= mem_rdata_i;
        end
    end

    assign proc_rdata_o = done_q ? {next_half_q, last_half_q} : line_shift[31:0];

    assign proc_stall_o = (state_q != icache_pkg::ST_IDLE)
                       || (proc_read_i && !done_q && (!arr.hit || span_need));

    assign mem_read_o = (state_q == icache_pkg::ST_REFILL);
    assign mem_addr_o = arr.line_addr;

    // request must hold until memory answers
    a_mem_addr_stable : assert property (
        @(posedge clk) disable iff (proc_reset_i)
        mem_read_o && !mem_ready_i |=> $stable(mem_addr_o)
    );

    // a refill never targets a line the store already holds
    a_fill_on_miss : assert property (
        @(posedge clk) disable iff (proc_reset_i)
        arr.fill |-> !arr.hit
    );

endmodule

// File: src/icache_pkg.sv
package icache_pkg;

    // processor side addresses halfwords
    localparam int ADDR_W = 31;

    // one line is eight halfwords and matches the memory bus width
    localparam int LINE_W = 128;

    // line address is the halfword address without the offset
    localparam int LINE_ADDR_W = 28;

    // line address split
    localparam int TAG_W   = 26;
    localparam int INDEX_W = 2;
    localparam int SETS    = 4;

    // halfword position inside a line
    localparam int OFFSET_W    = 3;
    localparam int LAST_OFFSET = 7;

    // fetch controller states
    // ST_IDLE    serving hits
    // ST_SPAN    second-line lookup for a 32-bit instruction across lines
    // ST_REFILL  waiting on memory
    // ST_FILL    writing the returned line into the store
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SPAN,
        ST_REFILL,
        ST_FILL
    } ctrl_state_e;

endpackage

// File: verification/i_cache_tb.sv
module i_cache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FETCH_TIMEOUT = 100;

    logic                               clk;
    logic                               proc_reset_i;
    logic                               proc_read_i;
    logic [icache_pkg::ADDR_W-1:0]      proc_addr_i;
    logic [31:0]                        proc_rdata_o;
    logic                               proc_stall_o;
    logic                               mem_read_o;
    logic [icache_pkg::LINE_ADDR_W-1:0] mem_addr_o;
    logic [icache_pkg::LINE_W-1:0]      mem_rdata_i;
    logic                               mem_ready_i;

    integer seed = 32'hc5ef;
    int     errors = 0;
    int     timeouts = 0;
    int     refill_count = 0;
    int     issued = 0;
    int     checked = 0;

    i_cache UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory contents with only 32-bit halfwords in lines of odd set index
    function automatic logic [15:0] gen_half(input logic [30:0] a);
        logic [15:0] mix;
        mix = (a[15:0] * 16'h3b1d) ^ a[30:15];
        gen_half = a[3] ? {mix[15:2], 2'b11} : {mix[15:2], 1'b0, mix[0]};
    endfunction

    function automatic logic [127:0] build_line(input logic [27:0] la);
        logic [127:0] line;
        for (int k = 0; k < 8; k++) begin
            line[16*k +: 16] = gen_half({la, 3'(k)});
        end
        build_line = line;
    endfunction

    // expected 32-bit window for a halfword address
    function automatic logic [31:0] ref_window(input logic [30:0] a);
        logic [15:0] lo;
        lo = gen_half(a);
        if (a[2:0] == 3'(icache_pkg::LAST_OFFSET) && lo[1:0] != 2'b11) begin
            ref_window = {16'h0000, lo};
        end else begin
            ref_window = {gen_half(a + 31'd1), lo};
        end
    endfunction

    // line memory with a random answer delay of 1 to 6 cycles
    initial begin : memory_model
        int delay;
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(posedge clk);
            if (!proc_reset_i && mem_read_o) begin
                delay = 1 + int'($unsigned($random(seed)) % 6);
                repeat (delay - 1) @(posedge clk);
                @(negedge clk);
                mem_rdata_i = build_line(mem_addr_o);
                mem_ready_i = 1'b1;
                refill_count++;
                @(negedge clk);
                mem_ready_i = 1'b0;
            end
        end
    end

    // every completing cycle is compared against the reference
    always @(posedge clk) begin
        if (!proc_reset_i && proc_read_i && !proc_stall_o) begin
            checked++;
            assert (proc_rdata_o === ref_window(proc_addr_i)) else begin
                errors++;
                $display("[FAIL] %0t ns: fetch at %h returned %h, expected %h",
                         $time, proc_addr_i, proc_rdata_o, ref_window(proc_addr_i));
            end
        end
    end

    task automatic expect_count(input string what, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("[FAIL] %0t ns: %s was %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // one fetch where a negative expectation is not checked
    task automatic fetch_expect(input logic [30:0] addr, input int exp_refills,
                                input int exp_stalls);
        int start;
        int stalls;
        start  = refill_count;
        stalls = 0;
        @(negedge clk);
        proc_read_i = 1'b1;
        proc_addr_i = addr;
        issued++;
        @(posedge clk);
        while (proc_stall_o && stalls < FETCH_TIMEOUT) begin
            stalls++;
            @(posedge clk);
        end
        if (proc_stall_o) begin
            timeouts++;
            $display("fetch at %h still stalled after %0d cycles, giving up on it",
                     addr, FETCH_TIMEOUT);
        end
        @(negedge clk);
        proc_read_i = 1'b0;
        if (exp_refills >= 0) expect_count("refills", refill_count - start, exp_refills);
        if (exp_stalls >= 0) expect_count("stall cycles", stalls, exp_stalls);
    endtask

    initial begin
        logic [30:0] off;
        proc_reset_i = 1'b1;
        proc_read_i  = 1'b0;
        proc_addr_i  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        proc_reset_i = 1'b0;

        // cold miss then a hit in the same line
        fetch_expect({28'h100, 3'd2}, 1, -1);
        fetch_expect({28'h100, 3'd5}, 0, 0);
        for (int k = 0; k < 7; k++) begin
            fetch_expect({28'h100, 3'(k)}, 0, 0);
        end

        // last offset with a compressed then a spanning halfword
        fetch_expect({28'h100, 3'd7}, 0, 0);
        fetch_expect({28'h101, 3'd0}, 1, -1);
        fetch_expect({28'h101, 3'd7}, 1, -1);
        fetch_expect({28'h101, 3'd7}, 0, 2);

        // set 3 replacement where B is the victim once A was touched
        fetch_expect({28'h203, 3'd1}, 1, -1);
        fetch_expect({28'h207, 3'd1}, 1, -1);
        fetch_expect({28'h203, 3'd1}, 0, 0);
        fetch_expect({28'h207, 3'd1}, 0, 0);
        fetch_expect({28'h203, 3'd1}, 0, 0);
        fetch_expect({28'h20b, 3'd1}, 1, -1);
        fetch_expect({28'h203, 3'd1}, 0, 0);
        fetch_expect({28'h207, 3'd1}, 1, -1);

        // random fetches over 16 lines with four per set
        for (int i = 0; i < 300; i++) begin
            off = 31'($unsigned($random(seed)) % 128);
            fetch_expect(31'h800 + off, -1, -1);
        end

        expect_count("fetches checked", checked, issued);
        $display("mismatches: %0d, timeouts: %0d, refills: %0d, fetches: %0d",
                 errors, timeouts, refill_count, checked);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
